//--- all.f
hdl/core_pkg.sv
hdl/regfile.sv
hdl/alu_lane.sv
hdl/issue_unit.sv
hdl/retire_unit.sv
hdl/dual_issue_core.sv
tb/core_tb.sv

//--- hdl/alu_lane.sv
`timescale 1ns/100ps

module alu_lane
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      disp_valid,
    input  alu_op_t   disp_op,
    input  word_t     disp_a,
    input  word_t     disp_b,
    input  logic [4:0] disp_shamt,
    input  reg_addr_t disp_rd,
    input  seq_t      disp_seq,
    output logic      res_valid,
    output word_t     res_value,
    output reg_addr_t res_rd,
    output seq_t      res_seq
);

    // stage one, operands
    logic       s1_valid;
    alu_op_t    s1_op;
    word_t      s1_a;
    word_t      s1_b;
    logic [4:0] s1_shamt;
    reg_addr_t  s1_rd;
    seq_t       s1_seq;

    word_t      alu_out;

    always_ff @(posedge clk) begin
        if (resetn) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= disp_valid;
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid) begin
            s1_op    <= disp_op;
            s1_a     <= disp_a;
            s1_b     <= disp_b;
            s1_shamt <= disp_shamt;
            s1_rd    <= disp_rd;
            s1_seq   <= disp_seq;
        end
        if (s1_valid) begin
            res_value <= alu_out;
            res_rd    <= s1_rd;
            res_seq   <= s1_seq;
        end
    end

    always_comb begin
        case (s1_op)
            ALU_ADD: alu_out = s1_a + s1_b;
            ALU_SUB: alu_out = s1_a - s1_b;
            ALU_AND: alu_out = s1_a & s1_b;
            ALU_OR:  alu_out = s1_a | s1_b;
            ALU_XOR: alu_out = s1_a ^ s1_b;
            // signed compare
            ALU_SLT: alu_out = {31'b0, $signed(s1_a) < $signed(s1_b)};
            ALU_SLL: alu_out = s1_b << s1_shamt;
            ALU_LUI: alu_out = {s1_b[15:0], 16'h0000};
            default: alu_out = '0;
        endcase
    end

endmodule

//--- hdl/core_pkg.sv
package core_pkg;

    // machine shape
    localparam int NUM_LANES    = 2;
    localparam int QUEUE_DEPTH  = 4;
    localparam int LANE_CREDITS = 2;
    localparam int NUM_REGS     = 32;
    localparam int NUM_RD_PORTS = 4;

    // derived widths
    localparam int QPTR_W     = $clog2(QUEUE_DEPTH);
    localparam int FIFO_PTR_W = $clog2(LANE_CREDITS);
    localparam int CREDIT_W   = $clog2(LANE_CREDITS + 1);

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    // program-order tag, wraps
    typedef logic [3:0]  seq_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI,
        ALU_NOP
    } alu_op_t;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f
    } opcode_t;

    // funct field of SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_t;

endpackage

//--- hdl/dual_issue_core.sv
`timescale 1ns/100ps

module dual_issue_core
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       instr_valid,
    input  instr_t     instr,
    output logic [1:0] instr_credit,
    output logic       retire_valid,
    output reg_addr_t  retire_rd,
    output word_t      retire_value
);

    // register file ports
    reg_addr_t rd_addr [NUM_RD_PORTS];
    word_t     rd_data [NUM_RD_PORTS];
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    // issue to lanes
    logic [NUM_LANES-1:0] disp_valid;
    alu_op_t              disp_op [NUM_LANES];
    word_t                disp_a [NUM_LANES];
    word_t                disp_b [NUM_LANES];
    logic [4:0]           disp_shamt [NUM_LANES];
    reg_addr_t            disp_rd [NUM_LANES];
    seq_t                 disp_seq [NUM_LANES];

    // lanes to retire
    logic [NUM_LANES-1:0] res_valid;
    word_t                res_value [NUM_LANES];
    reg_addr_t            res_rd [NUM_LANES];
    seq_t                 res_seq [NUM_LANES];
    logic [NUM_LANES-1:0] lane_credit;

    issue_unit u_issue (
        .clk          (clk),
        .resetn       (resetn),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .lane_credit  (lane_credit),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .rd_data      (rd_data),
        .instr_credit (instr_credit),
        .rd_addr      (rd_addr),
        .disp_valid   (disp_valid),
        .disp_op      (disp_op),
        .disp_a       (disp_a),
        .disp_b       (disp_b),
        .disp_shamt   (disp_shamt),
        .disp_rd      (disp_rd),
        .disp_seq     (disp_seq)
    );

    regfile u_regfile (
        .clk     (clk),
        .resetn  (resetn),
        .rd_addr (rd_addr),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_data (rd_data)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        alu_lane u_lane (
            .clk        (clk),
            .resetn     (resetn),
            .disp_valid (disp_valid[i]),
            .disp_op    (disp_op[i]),
            .disp_a     (disp_a[i]),
            .disp_b     (disp_b[i]),
            .disp_shamt (disp_shamt[i]),
            .disp_rd    (disp_rd[i]),
            .disp_seq   (disp_seq[i]),
            .res_valid  (res_valid[i]),
            .res_value  (res_value[i]),
            .res_rd     (res_rd[i]),
            .res_seq    (res_seq[i])
        );
    end

    retire_unit u_retire (
        .clk          (clk),
        .resetn       (resetn),
        .res_valid    (res_valid),
        .res_value    (res_value),
        .res_rd       (res_rd),
        .res_seq      (res_seq),
        .lane_credit  (lane_credit),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_value (retire_value)
    );

endmodule

//--- hdl/issue_unit.sv
`timescale 1ns/100ps

module issue_unit
    import core_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 instr_valid,
    input  instr_t               instr,
    input  logic [NUM_LANES-1:0] lane_credit,
    input  logic                 wr_en,
    input  reg_addr_t            wr_addr,
    input  word_t                rd_data [NUM_RD_PORTS],
    output logic [1:0]           instr_credit,
    output reg_addr_t            rd_addr [NUM_RD_PORTS],
    output logic [NUM_LANES-1:0] disp_valid,
    output alu_op_t              disp_op [NUM_LANES],
    output word_t                disp_a [NUM_LANES],
    output word_t                disp_b [NUM_LANES],
    output logic [4:0]           disp_shamt [NUM_LANES],
    output reg_addr_t            disp_rd [NUM_LANES],
    output seq_t                 disp_seq [NUM_LANES]
);

    instr_t              q_mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0]   q_head;
    logic [QPTR_W-1:0]   q_tail;
    logic [QPTR_W:0]     q_count;
    logic [NUM_REGS-1:0] pending;
    logic [NUM_REGS-1:0] busy;
    logic [NUM_REGS-1:0] pending_next;
    logic [CREDIT_W-1:0] credit_cnt [NUM_LANES];
    seq_t                next_seq;

    // decoded view of the two oldest entries
    logic [1:0] slot_valid;
    alu_op_t    dec_op [2];
    reg_addr_t  dec_rs [2];
    reg_addr_t  dec_rt [2];
    reg_addr_t  dec_rd [2];
    logic [4:0] dec_shamt [2];
    word_t      dec_imm [2];
    logic [1:0] dec_use_rs;
    logic [1:0] dec_use_rt;
    logic [1:0] dec_use_imm;
    word_t      opnd_b [2];

    logic [1:0] hazard;
    logic       cross_dep;
    logic       first_lane;
    logic       go0;
    logic       go1;
    logic [1:0] pops;

    assign q_tail = q_head + q_count[QPTR_W-1:0];

    always_comb begin
        instr_t ir;
        for (int k = 0; k < 2; k++) begin
            ir = q_mem[q_head + QPTR_W'(k)];
            slot_valid[k]  = q_count > k;
            dec_rs[k]      = ir[25:21];
            dec_rt[k]      = ir[20:16];
            dec_shamt[k]   = ir[10:6];
            dec_op[k]      = ALU_NOP;
            dec_rd[k]      = '0;
            dec_use_rs[k]  = 1'b0;
            dec_use_rt[k]  = 1'b0;
            dec_use_imm[k] = 1'b0;
            dec_imm[k]     = {16'h0000, ir[15:0]};
            case (ir[31:26])
                OP_SPECIAL: begin
                    dec_rd[k]     = ir[15:11];
                    dec_use_rs[k] = 1'b1;
                    dec_use_rt[k] = 1'b1;
                    case (ir[5:0])
                        FN_ADDU: dec_op[k] = ALU_ADD;
                        FN_SUBU: dec_op[k] = ALU_SUB;
                        FN_AND:  dec_op[k] = ALU_AND;
                        FN_OR:   dec_op[k] = ALU_OR;
                        FN_XOR:  dec_op[k] = ALU_XOR;
                        FN_SLT:  dec_op[k] = ALU_SLT;
                        FN_SLL: begin
                            dec_op[k]     = ALU_SLL;
                            dec_use_rs[k] = 1'b0;
                        end
                        default: dec_rd[k] = '0;
                    endcase
                end
                OP_ADDIU: begin
                    dec_op[k]      = ALU_ADD;
                    dec_rd[k]      = ir[20:16];
                    dec_use_rs[k]  = 1'b1;
                    dec_use_imm[k] = 1'b1;
                    dec_imm[k]     = {{16{ir[15]}}, ir[15:0]};
                end
                OP_ORI: begin
                    dec_op[k]      = ALU_OR;
                    dec_rd[k]      = ir[20:16];
                    dec_use_rs[k]  = 1'b1;
                    dec_use_imm[k] = 1'b1;
                end
                OP_LUI: begin
                    dec_op[k]      = ALU_LUI;
                    dec_rd[k]      = ir[20:16];
                    dec_use_imm[k] = 1'b1;
                end
                default: ;
            endcase
            // nothing to write, so retire as a plain no-op
            if (dec_rd[k] == '0) begin
                dec_op[k]     = ALU_NOP;
                dec_use_rs[k] = 1'b0;
                dec_use_rt[k] = 1'b0;
            end
        end
    end

    // a register being retired this cycle is no longer busy
    always_comb begin
        busy = pending;
        if (wr_en) begin
            busy[wr_addr] = 1'b0;
        end
        for (int k = 0; k < 2; k++) begin
            hazard[k] = (dec_use_rs[k] && busy[dec_rs[k]]) ||
                        (dec_use_rt[k] && busy[dec_rt[k]]) ||
                        busy[dec_rd[k]];
        end
    end

    assign cross_dep = (dec_rd[0] != '0) &&
                       ((dec_use_rs[1] && dec_rs[1] == dec_rd[0]) ||
                        (dec_use_rt[1] && dec_rt[1] == dec_rd[0]) ||
                        dec_rd[1] == dec_rd[0]);

    // oldest prefers lane 0, second takes the other lane
    assign first_lane = (credit_cnt[0] == '0);
    assign go0 = slot_valid[0] && !hazard[0] && credit_cnt[first_lane] != '0;
    assign go1 = go0 && slot_valid[1] && !hazard[1] && !cross_dep &&
                 credit_cnt[!first_lane] != '0;

    assign pops         = {1'b0, go0} + {1'b0, go1};
    assign instr_credit = {go1, go0};

    assign rd_addr[0] = dec_rs[0];
    assign rd_addr[1] = dec_rt[0];
    assign rd_addr[2] = dec_rs[1];
    assign rd_addr[3] = dec_rt[1];

    assign opnd_b[0] = dec_use_imm[0] ? dec_imm[0] : rd_data[1];
    assign opnd_b[1] = dec_use_imm[1] ? dec_imm[1] : rd_data[3];

    always_comb begin
        logic sel;
        for (int i = 0; i < NUM_LANES; i++) begin
            sel           = (1'(i) != first_lane);
            disp_valid[i] = sel ? go1 : go0;
            disp_op[i]    = dec_op[sel];
            disp_a[i]     = sel ? rd_data[2] : rd_data[0];
            disp_b[i]     = opnd_b[sel];
            disp_shamt[i] = dec_shamt[sel];
            disp_rd[i]    = dec_rd[sel];
            disp_seq[i]   = next_seq + seq_t'(sel);
        end
    end

    always_comb begin
        pending_next = busy;
        if (go0 && dec_rd[0] != '0) begin
            pending_next[dec_rd[0]] = 1'b1;
        end
        if (go1 && dec_rd[1] != '0) begin
            pending_next[dec_rd[1]] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            q_mem[q_tail] <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            q_head   <= '0;
            q_count  <= '0;
            pending  <= '0;
            next_seq <= '0;
            for (int i = 0; i < NUM_LANES; i++) begin
                credit_cnt[i] <= CREDIT_W'(LANE_CREDITS);
            end
        end else begin
            q_head   <= q_head + QPTR_W'(pops);
            q_count  <= q_count + (QPTR_W + 1)'(instr_valid) - (QPTR_W + 1)'(pops);
            pending  <= pending_next;
            next_seq <= next_seq + seq_t'(pops);
            for (int i = 0; i < NUM_LANES; i++) begin
                credit_cnt[i] <= credit_cnt[i] + CREDIT_W'(lane_credit[i])
                                 - CREDIT_W'(disp_valid[i]);
            end
        end
    end

    // the source must hold a credit, so a full queue never sees a push
    assert property (@(posedge clk) disable iff (resetn)
        instr_valid |-> q_count < QUEUE_DEPTH);

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_credit_chk
        assert property (@(posedge clk) disable iff (resetn)
            credit_cnt[i] <= LANE_CREDITS);
    end

endmodule

//--- hdl/regfile.sv
`timescale 1ns/100ps

module regfile
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  reg_addr_t rd_addr [NUM_RD_PORTS],
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output word_t     rd_data [NUM_RD_PORTS]
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through so issue can use a value in the cycle it retires
    always_comb begin
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            if (rd_addr[p] == '0) begin
                rd_data[p] = '0;
            end else if (wr_en && wr_addr == rd_addr[p]) begin
                rd_data[p] = wr_data;
            end else begin
                rd_data[p] = regs[rd_addr[p]];
            end
        end
    end

endmodule

//--- hdl/retire_unit.sv
`timescale 1ns/100ps

module retire_unit
    import core_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic [NUM_LANES-1:0] res_valid,
    input  word_t                res_value [NUM_LANES],
    input  reg_addr_t            res_rd [NUM_LANES],
    input  seq_t                 res_seq [NUM_LANES],
    output logic [NUM_LANES-1:0] lane_credit,
    output logic                 wr_en,
    output reg_addr_t            wr_addr,
    output word_t                wr_data,
    output logic                 retire_valid,
    output reg_addr_t            retire_rd,
    output word_t                retire_value
);

    word_t                 fifo_value [NUM_LANES][LANE_CREDITS];
    reg_addr_t             fifo_rd [NUM_LANES][LANE_CREDITS];
    seq_t                  fifo_seq [NUM_LANES][LANE_CREDITS];
    logic [FIFO_PTR_W-1:0] rd_ptr [NUM_LANES];
    logic [FIFO_PTR_W-1:0] wr_ptr [NUM_LANES];
    logic [CREDIT_W-1:0]   fifo_cnt [NUM_LANES];
    seq_t                  exp_seq;

    logic [NUM_LANES-1:0]  head_hit;
    logic [NUM_LANES-1:0]  pop;

    // pick the lane whose head is next in program order
    always_comb begin
        pop          = '0;
        retire_rd    = '0;
        retire_value = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            head_hit[i] = fifo_cnt[i] != '0 && fifo_seq[i][rd_ptr[i]] == exp_seq;
            if (head_hit[i] && pop == '0) begin
                pop[i]       = 1'b1;
                retire_rd    = fifo_rd[i][rd_ptr[i]];
                retire_value = fifo_value[i][rd_ptr[i]];
            end
        end
    end

    assign retire_valid = |pop;
    assign lane_credit  = pop;

    // r0 is never written
    assign wr_en   = retire_valid && retire_rd != '0;
    assign wr_addr = retire_rd;
    assign wr_data = retire_value;

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (res_valid[i]) begin
                fifo_value[i][wr_ptr[i]] <= res_value[i];
                fifo_rd[i][wr_ptr[i]]    <= res_rd[i];
                fifo_seq[i][wr_ptr[i]]   <= res_seq[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            exp_seq <= '0;
            for (int i = 0; i < NUM_LANES; i++) begin
                rd_ptr[i]   <= '0;
                wr_ptr[i]   <= '0;
                fifo_cnt[i] <= '0;
            end
        end else begin
            exp_seq <= exp_seq + seq_t'(retire_valid);
            for (int i = 0; i < NUM_LANES; i++) begin
                rd_ptr[i]   <= rd_ptr[i] + FIFO_PTR_W'(pop[i]);
                wr_ptr[i]   <= wr_ptr[i] + FIFO_PTR_W'(res_valid[i]);
                fifo_cnt[i] <= fifo_cnt[i] + CREDIT_W'(res_valid[i]) - CREDIT_W'(pop[i]);
            end
        end
    end

    // issue credits bound what a lane can hand over
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_fifo_chk
        assert property (@(posedge clk) disable iff (resetn)
            res_valid[i] |-> fifo_cnt[i] < LANE_CREDITS);
    end

    // tags are unique among everything in flight
    assert property (@(posedge clk) disable iff (resetn) $onehot0(head_hit));

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator, pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
    -f all.f -o core_tb_sim > build.log 2>&1 \
    && ./obj_dir/core_tb_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -qx "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- tb/core_tb.sv
`timescale 1ns/100ps

module core_tb
    import core_pkg::*;
();

    localparam int RESET_CYCLES   = 10;
    localparam int RANDOM_COUNT   = 400;
    localparam int CHAIN_COUNT    = 40;
    localparam int TOTAL_INSTRS   = RANDOM_COUNT + CHAIN_COUNT;
    localparam int DRAIN_IDLE     = 10;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_INSTRS + 200;

    logic       clk = 1'b0;
    logic       resetn;
    logic       instr_valid;
    instr_t     instr;
    logic [1:0] instr_credit;
    logic       retire_valid;
    reg_addr_t  retire_rd;
    word_t      retire_value;

    integer     seed;
    int         src_credits;
    int         sent_count;
    int         retired_count;
    int         cycle_count;
    int         mismatch_errors;
    int         other_errors;

    // architectural state of the reference model
    word_t      model_regs [NUM_REGS];
    reg_addr_t  exp_rd_q [$];
    word_t      exp_val_q [$];

    dual_issue_core u_dual_issue_core (
        .clk          (clk),
        .resetn       (resetn),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_credit (instr_credit),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_value (retire_value)
    );

    always #4 clk = ~clk;

    task automatic check_rd(input string name, input reg_addr_t expected, input reg_addr_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
            mismatch_errors++;
        end
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
            mismatch_errors++;
        end
    endtask

    // nothing may retire or free a queue slot here
    task automatic check_idle(input string when);
        if (retire_valid !== 1'b0) begin
            $display("retire_valid is not low %s at %0t", when, $time);
            other_errors++;
        end
        if (instr_credit !== 2'b00) begin
            $display("instr_credit is not zero %s at %0t", when, $time);
            other_errors++;
        end
    endtask

    function automatic instr_t enc_r(input reg_addr_t rs, input reg_addr_t rt, input reg_addr_t rd,
                                     input logic [4:0] sh, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic instr_t enc_i(input logic [5:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // mostly r0..r4 so that hazards show up often
    task automatic pick_reg(output reg_addr_t r);
        int roll;
        roll = int'({$random(seed)} % 8);
        if (roll < 5) begin
            r = reg_addr_t'(roll);
        end else begin
            r = reg_addr_t'($random(seed));
        end
    endtask

    task automatic gen_random_instr(output instr_t ins);
        int          kind;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        logic [4:0]  sh;
        kind = int'({$random(seed)} % 11);
        pick_reg(rs);
        pick_reg(rt);
        pick_reg(rd);
        imm = 16'($random(seed));
        sh  = 5'($random(seed));
        case (kind)
            0: ins = enc_r(rs, rt, rd, 5'd0, FN_ADDU);
            1: ins = enc_r(rs, rt, rd, 5'd0, FN_SUBU);
            2: ins = enc_r(rs, rt, rd, 5'd0, FN_AND);
            3: ins = enc_r(rs, rt, rd, 5'd0, FN_OR);
            4: ins = enc_r(rs, rt, rd, 5'd0, FN_XOR);
            5: ins = enc_r(rs, rt, rd, 5'd0, FN_SLT);
            6: ins = enc_r(5'd0, rt, rd, sh, FN_SLL);
            7: ins = enc_i(OP_ADDIU, rs, rd, imm);
            8: ins = enc_i(OP_ORI, rs, rd, imm);
            9: ins = enc_i(OP_LUI, 5'd0, rd, imm);
            default: begin
                // lw or jr, neither is implemented
                if (($random(seed) & 1) != 0) begin
                    ins = enc_i(6'h23, rs, rd, imm);
                end else begin
                    ins = enc_r(rs, rt, rd, sh, 6'h08);
                end
            end
        endcase
    endtask

    // r7 and r8 take turns, each reads the other
    task automatic gen_chain_instr(input int k, output instr_t ins);
        reg_addr_t   cur;
        reg_addr_t   prev;
        logic [15:0] imm;
        cur  = (k % 2 == 0) ? 5'd7 : 5'd8;
        prev = (k % 2 == 0) ? 5'd8 : 5'd7;
        imm  = 16'($random(seed));
        case (k % 4)
            0: ins = enc_i(OP_ADDIU, prev, cur, imm);
            1: ins = enc_r(prev, prev, cur, 5'd0, FN_ADDU);
            2: ins = enc_r(prev, 5'd3, cur, 5'd0, FN_XOR);
            default: ins = enc_r(5'd0, prev, cur, 5'd1, FN_SLL);
        endcase
    endtask

    // MIPS semantics, writes to r0 are dropped and report value 0
    task automatic model_exec(input instr_t ins, output reg_addr_t dst, output word_t val);
        word_t a;
        word_t b;
        word_t sext;
        word_t zext;
        a    = model_regs[ins[25:21]];
        b    = model_regs[ins[20:16]];
        sext = {{16{ins[15]}}, ins[15:0]};
        zext = {16'h0000, ins[15:0]};
        dst  = '0;
        val  = '0;
        case (ins[31:26])
            6'h00: begin
                dst = ins[15:11];
                case (ins[5:0])
                    6'h21: val = a + b;
                    6'h23: val = a - b;
                    6'h24: val = a & b;
                    6'h25: val = a | b;
                    6'h26: val = a ^ b;
                    6'h2a: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h00: val = b << ins[10:6];
                    default: dst = '0;
                endcase
            end
            6'h09: begin
                dst = ins[20:16];
                val = a + sext;
            end
            6'h0d: begin
                dst = ins[20:16];
                val = a | zext;
            end
            6'h0f: begin
                dst = ins[20:16];
                val = {ins[15:0], 16'h0000};
            end
            default: dst = '0;
        endcase
        if (dst == '0) begin
            val = '0;
        end else begin
            model_regs[dst] = val;
        end
    endtask

    // one cycle of the source, entered and left 1 ns after a rising edge
    task automatic run_cycle(input logic have_instr, input instr_t ins, output logic took);
        int        freed;
        reg_addr_t dst;
        word_t     val;
        freed = $countones(instr_credit);
        took  = 1'b0;
        if (have_instr && src_credits > 0 && ({$random(seed)} % 4) != 0) begin
            took        = 1'b1;
            instr_valid = 1'b1;
            instr       = ins;
            src_credits--;
            sent_count++;
            model_exec(ins, dst, val);
            exp_rd_q.push_back(dst);
            exp_val_q.push_back(val);
        end else begin
            instr_valid = 1'b0;
        end
        // slots freed now can be used from the next cycle on
        src_credits += freed;
        if (src_credits < 0 || src_credits > QUEUE_DEPTH) begin
            $display("source credit count out of range (%0d) at %0t", src_credits, $time);
            other_errors++;
        end
        @(posedge clk);
        #1;
    endtask

    always @(negedge clk) begin
        if (!resetn && retire_valid === 1'b1) begin
            if (exp_rd_q.size() == 0) begin
                $display("retire_valid high with no instruction outstanding at %0t", $time);
                other_errors++;
            end else begin
                check_rd("retire_rd", exp_rd_q.pop_front(), retire_rd);
                check_value("retire_value", exp_val_q.pop_front(), retire_value);
            end
            retired_count++;
        end else if (!resetn && retire_valid !== 1'b0) begin
            $display("retire_valid is unknown at %0t", $time);
            other_errors++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d sent instructions retired",
                     TIMEOUT_CYCLES, retired_count, sent_count);
            $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        instr_t next_instr;
        logic   have_next;
        logic   took;
        int     chain_idx;
        seed            = 23028;
        resetn          = 1'b1;
        instr_valid     = 1'b0;
        instr           = '0;
        src_credits     = QUEUE_DEPTH;
        sent_count      = 0;
        retired_count   = 0;
        cycle_count     = 0;
        mismatch_errors = 0;
        other_errors    = 0;
        have_next       = 1'b0;
        next_instr      = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_idle("during reset");
        end
        resetn = 1'b0;
        @(posedge clk);
        #1;
        check_idle("in the first cycle after reset");

        while (sent_count < RANDOM_COUNT) begin
            if (!have_next) begin
                gen_random_instr(next_instr);
                have_next = 1'b1;
            end
            run_cycle(1'b1, next_instr, took);
            if (took) begin
                have_next = 1'b0;
            end
        end

        chain_idx = 0;
        while (chain_idx < CHAIN_COUNT) begin
            if (!have_next) begin
                gen_chain_instr(chain_idx, next_instr);
                have_next = 1'b1;
            end
            run_cycle(1'b1, next_instr, took);
            if (took) begin
                have_next = 1'b0;
                chain_idx++;
            end
        end

        // drain, then idle a while to catch stray retires
        while (retired_count < sent_count) begin
            run_cycle(1'b0, '0, took);
        end
        repeat (DRAIN_IDLE) begin
            run_cycle(1'b0, '0, took);
        end

        if (exp_rd_q.size() != 0) begin
            $display("%0d expected results were never retired", exp_rd_q.size());
            other_errors++;
        end
        if (retired_count != sent_count) begin
            $display("retired %0d instructions but sent %0d", retired_count, sent_count);
            other_errors++;
        end
        if (src_credits != QUEUE_DEPTH) begin
            $display("source holds %0d credits after drain, expected %0d",
                     src_credits, QUEUE_DEPTH);
            other_errors++;
        end

        $display("errors: %0d mismatches, %0d other, %0d instructions retired",
                 mismatch_errors, other_errors, retired_count);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
